// ==== hw/fetch_defines.svh ====
//////////////////////////////////////////////////////////////////////
// fetch front end sizing macros
// address width, instruction memory size, buffer depth, reset pc
//////////////////////////////////////////////////////////////////////

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// byte address width of the pc
`define FETCH_ADDR_W      64

// 64-bit lines in the instruction memory, indexed by pc[10:3]
`define FETCH_IMEM_LINES  256

// instruction buffer entries, power of two and at least 4
`define FETCH_BUF_DEPTH   8

// pc loaded on reset, line aligned
`define FETCH_RESET_PC    64'h0

`endif

// ==== hw/fetch_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types of the fetch front end
// address, instruction, memory line, line index, fetch state
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

	// byte address, pc width
	typedef logic [`FETCH_ADDR_W-1:0] addr_t;

	typedef logic [31:0] inst_t;        // one instruction word
	typedef logic [63:0] line_t;        // two instructions, lower word at lower address
	typedef logic [7:0]  line_idx_t;    // memory line index, pc[10:3]

	// fetch stage occupancy
	typedef enum logic [1:0]
	{
		fetch_idle, // no bundle in flight
		fetch_run,  // bundle issued on the last edge
		fetch_hold  // bundle waiting on ready
	} fetch_state_e;

endpackage

`default_nettype wire

// ==== hw/fetch_bundle_if.sv ====
//////////////////////////////////////////////////////////////////////
// fetch to instruction buffer bundle
// one line-aligned pc and the two instructions of that line
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface fetch_bundle_if;
	import fetch_pkg::*;

	logic  valid;   // pair present
	logic  ready;   // buffer has room for a whole pair
	addr_t pc;      // line address of inst_lo
	inst_t inst_lo; // older instruction
	inst_t inst_hi; // younger instruction, pc + 4

	// program counter side
	modport producer
	(
		output valid,
		output pc,
		output inst_lo,
		output inst_hi,
		input  ready
	);

	// buffer side
	modport consumer
	(
		input  valid,
		input  pc,
		input  inst_lo,
		input  inst_hi,
		output ready
	);

endinterface

`default_nettype wire

// ==== hw/imem_array.sv ====
//////////////////////////////////////////////////////////////////////
// instruction memory of the fetch front end
// synchronous load port from the testbench, combinational read port
// read valid drops while the data side holds the memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module imem_array
(
	input  logic                 clock,
	input  logic                 load_valid,   // write strobe
	input  fetch_pkg::line_idx_t load_idx,     // line to write
	input  fetch_pkg::line_t     load_line,    // line contents
	input  fetch_pkg::addr_t     rd_addr,      // fetch byte address
	input  logic                 mem_busy,     // data access owns the memory
	output fetch_pkg::line_t     rd_line,      // line at rd_addr
	output logic                 rd_valid      // rd_line usable this cycle
);
	import fetch_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	// plain array, contents survive reset
	line_t mem [`FETCH_IMEM_LINES];

	line_idx_t rd_idx; // line selected by the fetch address

	// load port, one line per cycle
	always_ff @(posedge clock)
	begin
		if (load_valid)
		begin
			mem[load_idx] <= load_line;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////////////////////////

	// byte offset inside the line is dropped, bits above 10 wrap
	assign rd_idx = rd_addr[10:3];

	// same-cycle read, no latency
	assign rd_line = mem[rd_idx];

	// structural conflict with the data side
	// fetch sees no data while the port is taken
	assign rd_valid = !mem_busy;

endmodule

`default_nettype wire

// ==== hw/fetch_pc.sv ====
//////////////////////////////////////////////////////////////////////
// program counter and fetch register
// issues one line-aligned instruction pair per cycle into the bundle
// redirect reloads the pc and drops the waiting pair
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_pc
(
	input  logic             clock,
	input  logic             reset,
	input  logic             fetch_enable,   // fetch allowed to advance
	input  logic             redirect_valid, // taken branch resolved
	input  fetch_pkg::addr_t redirect_pc,    // branch target
	input  fetch_pkg::line_t rd_line,        // line at rd_addr
	input  logic             rd_valid,       // memory returned the line
	output fetch_pkg::addr_t rd_addr,        // current fetch address
	fetch_bundle_if.producer bundle
);
	import fetch_pkg::*;

	addr_t        pc_q;         // pc being fetched
	fetch_state_e state_q;
	fetch_state_e state_n;
	addr_t        bundle_pc_q;  // payload of the fetch register
	inst_t        inst_lo_q;
	inst_t        inst_hi_q;
	logic         can_load;     // fetch register empty or draining
	logic         advance;      // take the line and step the pc

	// pc is kept aligned, mask anyway so the memory sees a line address
	assign rd_addr = {pc_q[`FETCH_ADDR_W-1:3], 3'b000};

	assign can_load = (state_q == fetch_idle) || bundle.ready;
	assign advance  = fetch_enable && rd_valid && can_load;

	//////////////////////////////////////////////////////////////////////
	// stage state
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (redirect_valid)
			state_n = fetch_idle;                  // wrong path pair dropped
		else if (advance)
			state_n = fetch_run;                   // fresh pair next cycle
		else if ((state_q != fetch_idle) && !bundle.ready)
			state_n = fetch_hold;                  // pair still waiting
		else
			state_n = fetch_idle;                  // drained, nothing new
	end

	// pc and state
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc_q    <= addr_t'(`FETCH_RESET_PC);
			state_q <= fetch_idle;
		end
		else
		begin
			state_q <= state_n;
			if (redirect_valid)
				pc_q <= {redirect_pc[`FETCH_ADDR_W-1:3], 3'b000}; // overrides every stall
			else if (advance)
				pc_q <= pc_q + addr_t'(8);  // next line
		end
	end

	//////////////////////////////////////////////////////////////////////
	// fetch register
	//////////////////////////////////////////////////////////////////////

	// payload only moves when a new pair is taken, so it holds while valid waits
	always_ff @(posedge clock)
	begin
		if (advance && !redirect_valid)
		begin
			bundle_pc_q <= rd_addr;
			inst_lo_q   <= rd_line[31:0];  // lower address
			inst_hi_q   <= rd_line[63:32];
		end
	end

	assign bundle.valid   = (state_q != fetch_idle);
	assign bundle.pc      = bundle_pc_q;
	assign bundle.inst_lo = inst_lo_q;
	assign bundle.inst_hi = inst_hi_q;

endmodule

`default_nettype wire

// ==== hw/inst_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// instruction buffer between fetch and decode
// circular buffer of instruction and pc entries, two in, up to two out
// flush empties it on a redirect
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module inst_buffer
(
	input  logic             clock,
	input  logic             reset,
	input  logic             flush,       // redirect, drop everything
	fetch_bundle_if.consumer bundle,
	output logic             dec_valid0,  // oldest entry present
	output logic             dec_valid1,  // second oldest present
	output fetch_pkg::inst_t dec_inst0,
	output fetch_pkg::inst_t dec_inst1,
	output fetch_pkg::addr_t dec_pc0,
	output fetch_pkg::addr_t dec_pc1,
	input  logic             dec_ready    // decode takes all valid slots
);
	import fetch_pkg::*;

	localparam int unsigned DEPTH = `FETCH_BUF_DEPTH;
	localparam int unsigned PTR_W = $clog2(DEPTH);
	localparam int unsigned CNT_W = PTR_W + 1;  // count reaches DEPTH

	inst_t            inst_mem [DEPTH];  // instruction per entry
	addr_t            pc_mem [DEPTH];    // its pc
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W-1:0] wr_ptr_hi;         // slot for inst_hi
	logic [PTR_W-1:0] rd_ptr_hi;         // second oldest slot
	logic [CNT_W-1:0] count_q;           // occupied entries
	logic             push;              // pair transfers this edge
	logic [1:0]       pop_n;             // entries leaving this edge

	//////////////////////////////////////////////////////////////////////
	// write side
	//////////////////////////////////////////////////////////////////////

	// room for a whole pair
	assign bundle.ready = (count_q <= CNT_W'(DEPTH - 2));
	assign push         = bundle.valid && bundle.ready;

	assign wr_ptr_hi = wr_ptr_q + PTR_W'(1);  // wraps, depth is a power of two

	// entries carry no reset, count decides what is live
	always_ff @(posedge clock)
	begin
		if (push && !flush)
		begin
			inst_mem[wr_ptr_q]  <= bundle.inst_lo;
			pc_mem[wr_ptr_q]    <= bundle.pc;
			inst_mem[wr_ptr_hi] <= bundle.inst_hi;
			pc_mem[wr_ptr_hi]   <= bundle.pc + addr_t'(4);  // second word of the line
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read side
	//////////////////////////////////////////////////////////////////////

	assign rd_ptr_hi = rd_ptr_q + PTR_W'(1);

	// slot 0 is always the older one, slot 1 only with slot 0
	assign dec_valid0 = (count_q != '0);
	assign dec_valid1 = (count_q >= CNT_W'(2));
	assign dec_inst0  = inst_mem[rd_ptr_q];
	assign dec_inst1  = inst_mem[rd_ptr_hi];
	assign dec_pc0    = pc_mem[rd_ptr_q];
	assign dec_pc1    = pc_mem[rd_ptr_hi];

	// number of valid slots consumed
	assign pop_n = dec_ready ? ({1'b0, dec_valid0} + {1'b0, dec_valid1}) : 2'd0;

	// pointers and count
	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= wr_ptr_q + PTR_W'(2);
			rd_ptr_q <= rd_ptr_q + PTR_W'(pop_n);
			count_q  <= count_q + CNT_W'({push, 1'b0}) - CNT_W'(pop_n);
		end
	end

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
//////////////////////////////////////////////////////////////////////
// fetch front end top level
// instruction memory, program counter and instruction buffer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_top
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 fetch_enable,
	input  logic                 redirect_valid,  // taken branch
	input  fetch_pkg::addr_t     redirect_pc,
	input  logic                 mem_busy,        // data side owns the memory
	input  logic                 load_valid,      // memory load port
	input  fetch_pkg::line_idx_t load_idx,
	input  fetch_pkg::line_t     load_line,
	output logic                 dec_valid0,
	output logic                 dec_valid1,
	output fetch_pkg::inst_t     dec_inst0,
	output fetch_pkg::inst_t     dec_inst1,
	output fetch_pkg::addr_t     dec_pc0,
	output fetch_pkg::addr_t     dec_pc1,
	input  logic                 dec_ready
);
	import fetch_pkg::*;

	addr_t rd_addr;   // fetch address to memory
	line_t rd_line;   // line back from memory
	logic  rd_valid;

	fetch_bundle_if bundle_if ();  // pc to buffer link

	imem_array imem_i
	(
		.clock      (clock),
		.load_valid (load_valid),
		.load_idx   (load_idx),
		.load_line  (load_line),
		.rd_addr    (rd_addr),
		.mem_busy   (mem_busy),
		.rd_line    (rd_line),
		.rd_valid   (rd_valid)
	);

	fetch_pc pc_i
	(
		.clock          (clock),
		.reset          (reset),
		.fetch_enable   (fetch_enable),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.rd_line        (rd_line),
		.rd_valid       (rd_valid),
		.rd_addr        (rd_addr),
		.bundle         (bundle_if.producer)
	);

	// redirect also flushes the wrong path out of the buffer
	inst_buffer buf_i
	(
		.clock      (clock),
		.reset      (reset),
		.flush      (redirect_valid),
		.bundle     (bundle_if.consumer),
		.dec_valid0 (dec_valid0),
		.dec_valid1 (dec_valid1),
		.dec_inst0  (dec_inst0),
		.dec_inst1  (dec_inst1),
		.dec_pc0    (dec_pc0),
		.dec_pc1    (dec_pc1),
		.dec_ready  (dec_ready)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
// 4 ns clock, reset held for the first 16 rising edges
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
	output logic clock,
	output logic reset
);
	initial clock = 1'b0;
	always #2 clock = ~clock;  // half period

	initial
	begin
		reset = 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;  // released on an edge like any other input
	end

endmodule

`default_nettype wire

// ==== dv/fetch_sva.sv ====
//////////////////////////////////////////////////////////////////////
// concurrent checks on the fetch front end
// slot order, bundle hold, idle after reset, redirect drop
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_sva
(
	input logic             clock,
	input logic             reset,
	input logic             redirect_valid,
	input logic             dec_valid0,
	input logic             dec_valid1,
	input logic             bundle_valid,
	input logic             bundle_ready,
	input fetch_pkg::addr_t bundle_pc,
	input fetch_pkg::inst_t bundle_inst_lo,
	input fetch_pkg::inst_t bundle_inst_hi
);
	// younger slot never shows alone
	a_slot_order: assert property (@(posedge clock) disable iff (reset)
		dec_valid1 |-> dec_valid0)
		else $error("dec_valid1 high without dec_valid0");

	// a waiting pair keeps its payload until the buffer takes it
	a_bundle_hold: assert property (@(posedge clock) disable iff (reset)
		(bundle_valid && !bundle_ready && !redirect_valid) |=>
		(bundle_valid && $stable(bundle_pc) && $stable(bundle_inst_lo)
			&& $stable(bundle_inst_hi)))
		else $error("bundle changed while waiting on ready");

	a_idle_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> (!dec_valid0 && !dec_valid1))
		else $error("decode slots valid right after reset");

	// wrong path pair is gone one cycle after the redirect
	a_redirect_drop: assert property (@(posedge clock) disable iff (reset)
		redirect_valid |=> !bundle_valid)
		else $error("bundle still valid after a redirect");

endmodule

bind fetch_top fetch_sva sva_i
(
	.clock          (clock),
	.reset          (reset),
	.redirect_valid (redirect_valid),
	.dec_valid0     (dec_valid0),
	.dec_valid1     (dec_valid1),
	.bundle_valid   (bundle_if.valid),
	.bundle_ready   (bundle_if.ready),
	.bundle_pc      (bundle_if.pc),
	.bundle_inst_lo (bundle_if.inst_lo),
	.bundle_inst_hi (bundle_if.inst_hi)
);

`default_nettype wire

// ==== dv/fetch_tb.sv ====
//////////////////////////////////////////////////////////////////////
// fetch front end testbench
// directed tests, stream reference model, lfsr, compare tasks, report
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_tb;
	import fetch_pkg::*;

	logic clock;
	logic reset;
	logic fetch_enable, redirect_valid, mem_busy, load_valid, dec_ready;
	addr_t redirect_pc, dec_pc0, dec_pc1;
	line_idx_t load_idx;
	line_t load_line;
	logic dec_valid0, dec_valid1;
	inst_t dec_inst0, dec_inst1;

	int inst_errors, pc_errors, flag_errors, timeout_errors;
	int delivered;        // slots consumed by decode since arming
	logic check_on;       // reference model active
	addr_t exp_pc;        // pc of the next slot decode must see
	addr_t arm_pc;        // start pc loaded while the model is idle
	inst_t cur_key;       // xor constant of the loaded program
	logic [15:0] lfsr;

	tb_clock_gen clk_i (.clock(clock), .reset(reset));

	fetch_top dut_i
	(
		.clock(clock), .reset(reset), .fetch_enable(fetch_enable),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .mem_busy(mem_busy),
		.load_valid(load_valid), .load_idx(load_idx), .load_line(load_line),
		.dec_valid0(dec_valid0), .dec_valid1(dec_valid1),
		.dec_inst0(dec_inst0), .dec_inst1(dec_inst1),
		.dec_pc0(dec_pc0), .dec_pc1(dec_pc1), .dec_ready(dec_ready)
	);

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		int k;
		begin
			v = '0;
			for (k = 0; k < n; k++)
			begin
				lfsr = lfsr_step(lfsr);   // one step per bit
				v = {v[14:0], lfsr[0]};
			end
		end
	endtask

	// memory word = its byte address xor key, memory wraps at 2 KiB
	function automatic inst_t expected_inst(input addr_t pc);
		return inst_t'(pc[10:0]) ^ cur_key;
	endfunction

	task automatic compare_inst(input string what, input inst_t got, input inst_t exp);
		if (got !== exp)
		begin
			$display("error at %0t: %s inst got %h expected %h", $time, what, got, exp);
			inst_errors++;
		end
	endtask

	task automatic compare_pc(input string what, input addr_t got, input addr_t exp);
		if (got !== exp)
		begin
			$display("error at %0t: %s pc got %h expected %h", $time, what, got, exp);
			pc_errors++;
		end
	endtask

	task automatic compare_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error at %0t: %s got %b expected %b", $time, what, got, exp);
			flag_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model, samples at the falling edge where all is stable
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock)
	begin
		if (!check_on || reset)
		begin
			exp_pc = arm_pc;      // idle, wait for the next stream
			delivered = 0;
		end
		else if (redirect_valid)
			exp_pc = redirect_pc & ~addr_t'(7);  // target line, old path dropped
		else if (dec_ready)
		begin
			if (dec_valid0)
			begin
				compare_pc("slot 0", dec_pc0, exp_pc);
				compare_inst("slot 0", dec_inst0, expected_inst(exp_pc));
				exp_pc = exp_pc + addr_t'(4);
				delivered = delivered + 1;
			end
			if (dec_valid1)
			begin
				compare_pc("slot 1", dec_pc1, exp_pc);
				compare_inst("slot 1", dec_inst1, expected_inst(exp_pc));
				exp_pc = exp_pc + addr_t'(4);
				delivered = delivered + 1;
			end
		end
	end

	task automatic wait_delivered(input int target, input int limit, input string what);
		int cycles;
		begin
			cycles = 0;
			while (delivered < target && cycles < limit)
			begin
				@(posedge clock);
				cycles++;
			end
			if (delivered < target)
			begin
				$display("timeout in %s: %0d of %0d instructions reached decode",
					what, delivered, target);
				timeout_errors++;
			end
		end
	endtask

	// one line per cycle through the load port
	task automatic load_program(input inst_t key);
		int i;
		inst_t base;
		begin
			cur_key = key;
			for (i = 0; i < `FETCH_IMEM_LINES; i++)
			begin
				base = inst_t'(i * 8);
				@(posedge clock);
				load_valid <= 1'b1;
				load_idx   <= line_idx_t'(i);
				load_line  <= {(base + inst_t'(4)) ^ key, base ^ key};
			end
			@(posedge clock);
			load_valid <= 1'b0;
		end
	endtask

	task automatic arm_model(input addr_t start);
		begin
			arm_pc = start;
			repeat (2) @(posedge clock);  // model copies arm_pc in between
			check_on = 1'b1;
		end
	endtask

	// park fetch, flush by redirect, reload, arm
	task automatic prepare_run(input addr_t start, input inst_t key);
		begin
			check_on = 1'b0;
			@(posedge clock);
			fetch_enable <= 1'b0;
			dec_ready    <= 1'b1;
			mem_busy     <= 1'b0;
			@(posedge clock);
			redirect_valid <= 1'b1;
			redirect_pc    <= start;
			@(posedge clock);
			redirect_valid <= 1'b0;
			load_program(key);
			arm_model(start);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset;
		int cycles;
		logic done;
		begin
			cycles = 0;
			done = 1'b0;
			@(posedge clock);
			while (!done && cycles < 100)
			begin
				@(negedge clock);
				compare_flag("dec_valid0 near reset", dec_valid0, 1'b0);
				compare_flag("dec_valid1 near reset", dec_valid1, 1'b0);
				done = !reset;  // last pass is the first cycle after reset
				cycles++;
			end
			if (!done)
			begin
				$display("timeout: reset never released");
				timeout_errors++;
			end
			load_program(inst_t'(32'h0bad_f00d));  // fetch still disabled, pc at reset value
			arm_model(addr_t'(`FETCH_RESET_PC));
			@(posedge clock);
			dec_ready    <= 1'b1;
			fetch_enable <= 1'b1;
			wait_delivered(8, 100, "first fetch after reset");
		end
	endtask

	task automatic test_sequential;
		begin
			prepare_run(addr_t'(64'h40), inst_t'(32'h1357_9bdf));
			@(posedge clock);
			fetch_enable <= 1'b1;
			wait_delivered(40, 200, "sequential stream");
		end
	endtask

	// random decode stalls fill the buffer and freeze the pc
	task automatic test_backpressure;
		int cycles;
		logic [15:0] r;
		begin
			prepare_run(addr_t'(64'h200), inst_t'(32'hc3a5_9600));
			cycles = 0;
			@(posedge clock);
			fetch_enable <= 1'b1;
			while (delivered < 40 && cycles < 2000)
			begin
				@(posedge clock);
				take_bits(1, r);
				dec_ready <= r[0];
				cycles++;
			end
			if (delivered < 40)
			begin
				$display("timeout: decode back-pressure stream stopped at %0d", delivered);
				timeout_errors++;
			end
			@(posedge clock);
			dec_ready <= 1'b1;
		end
	endtask

	task automatic test_stalls;
		int cycles;
		logic [15:0] r;
		begin
			prepare_run(addr_t'(64'h7c0), inst_t'(32'h8421_7777));  // wraps the memory
			cycles = 0;
			while (delivered < 40 && cycles < 2000)
			begin
				@(posedge clock);
				take_bits(3, r);
				mem_busy     <= r[0];            // data side conflict
				fetch_enable <= !(r[1] && r[2]); // enable low a quarter of the time
				cycles++;
			end
			if (delivered < 40)
			begin
				$display("timeout: stalled stream stopped at %0d", delivered);
				timeout_errors++;
			end
			@(posedge clock);
			mem_busy     <= 1'b0;
			fetch_enable <= 1'b1;
		end
	endtask

	task automatic test_redirect;
		int n;
		int base;
		logic [15:0] r;
		addr_t target;
		begin
			prepare_run(addr_t'(64'h100), inst_t'(32'h5a5a_0f0f));
			@(posedge clock);
			fetch_enable <= 1'b1;
			for (n = 0; n < 4; n++)
			begin
				wait_delivered(delivered + 6, 100, "stream before redirect");
				take_bits(2, r);
				repeat (r[1:0]) @(posedge clock);  // random point in the stream
				take_bits(11, r);
				target = addr_t'(64'h1_0000) | addr_t'(r[10:0]);  // line plus low-bit offset
				@(posedge clock);
				redirect_valid <= 1'b1;
				redirect_pc    <= target;
				@(posedge clock);
				redirect_valid <= 1'b0;
				base = delivered;
				wait_delivered(base + 10, 100, "stream after redirect");
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// run
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		fetch_enable   = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		mem_busy       = 1'b0;
		load_valid     = 1'b0;
		load_idx       = '0;
		load_line      = '0;
		dec_ready      = 1'b0;
		check_on       = 1'b0;
		arm_pc         = '0;
		cur_key        = '0;
		lfsr           = 16'd62855;
		inst_errors    = 0;
		pc_errors      = 0;
		flag_errors    = 0;
		timeout_errors = 0;

		test_reset();
		test_sequential();
		test_backpressure();
		test_stalls();
		test_redirect();

		check_on = 1'b0;
		repeat (4) @(posedge clock);
		$display("errors: inst %0d pc %0d flag %0d timeout %0d",
			inst_errors, pc_errors, flag_errors, timeout_errors);
		if (inst_errors + pc_errors + flag_errors + timeout_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_bundle_if.sv
hw/imem_array.sv
hw/fetch_pc.sv
hw/inst_buffer.sv
hw/fetch_top.sv
dv/tb_clock_gen.sv
dv/fetch_sva.sv
dv/fetch_tb.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module fetch_tb -f vlog.f -Mdir obj_dir -o fetch_sim
	./obj_dir/fetch_sim 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
